//--- list.f
common/sprite_pkg.sv
hw/sprite_rom.sv
draw_sprite/draw_sprite.sv
draw_sprite/scene_sequencer.sv
hw/pixel_filter.sv
hw/sprite_scene_top.sv
tb/sprite_scene_properties.sv
tb/tb_sprite_scene.sv

//--- run.sh
#!/bin/sh
# Compile the sprite scene testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_exe=sim_tb

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_sprite_scene \
    -Mdir "$build_dir" -o "$sim_exe"
status=$?
if [ $status -ne 0 ]; then
    echo "run.sh: verilator build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$log_file"; then
    echo "run.sh: simulation passed"
    exit 0
else
    echo "run.sh: pass message not found in $log_file"
    exit 1
fi

//--- tb/tb_sprite_scene.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_scene import sprite_pkg::*; ();

    localparam int sprite_size     = 20;
    localparam int npix            = sprite_size * sprite_size;
    localparam int num_scenes      = 5;
    localparam int clk_period      = 10;
    localparam int frame_cycles    = 2 * npix + 20;
    localparam int watchdog_cycles = num_scenes * frame_cycles + 2 * npix + 10 + 20;

    typedef struct packed {
        coord_t      car;
        coord_t      tower;
        logic [15:0] restart_at; // Cycle of an extra frame_start, 0 for none
    } scene_t;

    // Positions on screen, across the right and bottom edges, and fully off screen
    scene_t scenes [num_scenes] = '{
        '{'{8'd10, 7'd10}, '{8'd60, 7'd40}, 16'd0},
        '{'{8'd150, 7'd110}, '{8'd0, 7'd0}, 16'd0},
        '{'{8'd100, 7'd60}, '{8'd140, 7'd100}, 16'd300},
        '{'{8'd250, 7'd125}, '{8'd120, 7'd5}, 16'd600},
        '{'{8'd30, 7'd112}, '{8'd145, 7'd2}, 16'd0}
    };

    logic         clk;
    logic         resetn;
    logic         frame_start;
    coord_t       car_pos;
    coord_t       tower_pos;
    sprite_load_t load;
    pix_write_t   pix_out;
    logic         frame_done;
    logic         busy;

    colour_t    images [2][npix]; // Index 0 is the car, 1 the tower
    pix_write_t expected [$];

    sprite_scene_top #(.sprite_size(sprite_size)) dut_i (
        .clk        (clk),
        .resetn     (resetn),
        .frame_start(frame_start),
        .car_pos    (car_pos),
        .tower_pos  (tower_pos),
        .load       (load),
        .pix_out    (pix_out),
        .frame_done (frame_done),
        .busy       (busy)
    );

    bind sprite_scene_top sprite_scene_properties props_i (
        .clk       (clk),
        .resetn    (resetn),
        .pix_out   (pix_out),
        .frame_done(frame_done),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic fill_images();
        int s;
        int i;
        for (s = 0; s < 2; s++) begin
            for (i = 0; i < npix; i++) begin
                images[s][i] = 9'($urandom() % 511); // Any colour but the key
                if (($urandom() % 8) == 0) begin
                    images[s][i] = colour_key;
                end
            end
        end
    endtask

    task automatic load_images();
        int s;
        int i;
        for (s = 0; s < 2; s++) begin
            for (i = 0; i < npix; i++) begin
                load.valid  = 1'b1;
                load.sel    = (s == 0) ? sel_car : sel_tower;
                load.addr   = 9'(i);
                load.colour = images[s][i];
                @(negedge clk);
            end
        end
        load = '0;
        @(negedge clk);
    endtask

    // Row-major writes of one sprite, skipping the key and anything off screen
    task automatic add_sprite(input coord_t pos, input int which);
        int r;
        int c;
        int x;
        int y;
        pix_write_t w;
        for (r = 0; r < sprite_size; r++) begin
            for (c = 0; c < sprite_size; c++) begin
                x = int'(pos.x) + c;
                y = int'(pos.y) + r;
                w.valid  = 1'b1;
                w.x      = 8'(x);
                w.y      = 7'(y);
                w.colour = images[which][r * sprite_size + c];
                if (w.colour != colour_key && x < screen_w && y < screen_h) begin
                    expected.push_back(w);
                end
            end
        end
    endtask

    task automatic run_scene(input int idx);
        int         cycle;
        int         writes;
        int         exp_total;
        bit         done_seen;
        pix_write_t exp_pix;
        expected.delete();
        add_sprite(scenes[idx].car, 0);
        add_sprite(scenes[idx].tower, 1); // Tower always follows the car
        exp_total   = expected.size();
        car_pos     = scenes[idx].car;
        tower_pos   = scenes[idx].tower;
        frame_start = 1'b1;
        @(negedge clk);
        frame_start = 1'b0;
        car_pos     = coord_t'(15'($urandom())); // Must not matter after the strobe
        tower_pos   = coord_t'(15'($urandom()));
        cycle       = 0;
        writes      = 0;
        done_seen   = 1'b0;
        while (!done_seen) begin
            if (cycle == 0) begin
                check("busy", 32'(busy), 32'd1);
            end
            if (pix_out.valid) begin
                if (expected.size() == 0) begin
                    abort_run($sformatf("scene %0d wrote more pixels than expected", idx));
                end else begin
                    exp_pix = expected.pop_front();
                    check("pix_out.x", 32'(pix_out.x), 32'(exp_pix.x));
                    check("pix_out.y", 32'(pix_out.y), 32'(exp_pix.y));
                    check("pix_out.colour", 32'(pix_out.colour), 32'(exp_pix.colour));
                    writes++;
                end
            end
            if (frame_done) begin
                done_seen = 1'b1;
            end
            frame_start = 1'b0;
            if (scenes[idx].restart_at != 0 && cycle == int'(scenes[idx].restart_at)) begin
                check("busy", 32'(busy), 32'd1); // Strobe lands mid-frame
                frame_start = 1'b1;
            end
            @(negedge clk);
            cycle++;
        end
        frame_start = 1'b0;
        repeat (4) begin
            check("pix_out.valid", 32'(pix_out.valid), 32'd0);
            check("frame_done", 32'(frame_done), 32'd0);
            check("busy", 32'(busy), 32'd0);
            @(negedge clk);
        end
        check("write count", 32'(writes), 32'(exp_total));
        $display("scene %0d: %0d writes in %0d cycles", idx, writes, cycle);
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        abort_run($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
    end

    initial begin
        int i;
        void'($urandom(32'h4844bd59));
        resetn      = 1'b0;
        frame_start = 1'b0;
        car_pos     = '0;
        tower_pos   = '0;
        load        = '0;
        fill_images();
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        check("pix_out.valid", 32'(pix_out.valid), 32'd0);
        check("frame_done", 32'(frame_done), 32'd0);
        check("busy", 32'(busy), 32'd0);
        load_images();
        for (i = 0; i < num_scenes; i++) begin
            run_scene(i);
        end
        if (dut_i.props_i.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("%0d assertion failures", dut_i.props_i.fail_count);
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/sprite_scene_properties.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_scene_properties import sprite_pkg::*; (
    input wire logic       clk,
    input wire logic       resetn,
    input wire pix_write_t pix_out,
    input wire logic       frame_done,
    input wire logic       busy
);

    int fail_count = 0;

    // Outputs quiet once reset has been seen
    reset_quiet: assert property (@(posedge clk)
        !resetn |=> (!pix_out.valid && !frame_done && !busy))
        else begin
            fail_count++;
            $error("outputs not low after reset");
        end

    done_single: assert property (@(posedge clk) disable iff (!resetn)
        frame_done |=> !frame_done) // Pulse, never a level
        else begin
            fail_count++;
            $error("frame_done held for more than one cycle");
        end

    busy_drops: assert property (@(posedge clk) disable iff (!resetn)
        frame_done |=> !busy)
        else begin
            fail_count++;
            $error("busy still high after frame_done");
        end

    // Every write lands on screen with a visible colour
    write_legal: assert property (@(posedge clk) disable iff (!resetn)
        pix_out.valid |-> (pix_out.colour != colour_key
                           && pix_out.x < 8'(screen_w)
                           && pix_out.y < 7'(screen_h)))
        else begin
            fail_count++;
            $error("write off screen or with the colour key");
        end

endmodule

`default_nettype wire

//--- hw/sprite_scene_top.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_scene_top import sprite_pkg::*; #(
    parameter int sprite_size = 20
) (
    input  wire logic         clk,
    input  wire logic         resetn,
    input  wire logic         frame_start,
    input  wire coord_t       car_pos,
    input  wire coord_t       tower_pos,
    input  wire sprite_load_t load,
    output pix_write_t        pix_out,
    output logic              frame_done,
    output logic              busy
);

    logic       car_start;
    logic       tower_start;
    coord_t     car_origin;
    coord_t     tower_origin;
    logic       car_done;
    logic       tower_done;
    pix_write_t car_pix;
    pix_write_t tower_pix;
    pix_write_t merged_pix;
    logic       car_we;
    logic       tower_we;

    // Route each load word to the selected image
    assign car_we   = load.valid && (load.sel == sel_car);
    assign tower_we = load.valid && (load.sel == sel_tower);

    scene_sequencer seq_i (
        .clk         (clk),
        .resetn      (resetn),
        .frame_start (frame_start),
        .car_pos     (car_pos),
        .tower_pos   (tower_pos),
        .car_done    (car_done),
        .tower_done  (tower_done),
        .car_pix     (car_pix),
        .tower_pix   (tower_pix),
        .car_start   (car_start),
        .tower_start (tower_start),
        .car_origin  (car_origin),
        .tower_origin(tower_origin),
        .pix         (merged_pix),
        .frame_done  (frame_done),
        .busy        (busy)
    );

    draw_sprite #(.sprite_size(sprite_size)) car_i (
        .clk        (clk),
        .resetn     (resetn),
        .start      (car_start),
        .origin     (car_origin),
        .load_we    (car_we),
        .load_addr  (load.addr),
        .load_colour(load.colour),
        .pix        (car_pix),
        .done       (car_done)
    );

    draw_sprite #(.sprite_size(sprite_size)) tower_i (
        .clk        (clk),
        .resetn     (resetn),
        .start      (tower_start),
        .origin     (tower_origin),
        .load_we    (tower_we),
        .load_addr  (load.addr),
        .load_colour(load.colour),
        .pix        (tower_pix),
        .done       (tower_done)
    );

    pixel_filter filter_i (
        .clk    (clk),
        .resetn (resetn),
        .pix_in (merged_pix),
        .pix_out(pix_out)
    );

endmodule

`default_nettype wire

//--- hw/pixel_filter.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_filter import sprite_pkg::*; (
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire pix_write_t pix_in,
    output pix_write_t      pix_out
);

    logic       keep;
    logic       valid_q;
    logic [7:0] x_q;
    logic [6:0] y_q;
    colour_t    colour_q;

    // Drop transparent and off-screen pixels
    assign keep = pix_in.valid
               && (pix_in.colour != colour_key)
               && (pix_in.x < 8'(screen_w))
               && (pix_in.y < 7'(screen_h));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= keep;
        end
    end

    always_ff @(posedge clk) begin
        x_q      <= pix_in.x;
        y_q      <= pix_in.y;
        colour_q <= pix_in.colour;
    end

    assign pix_out.valid  = valid_q;
    assign pix_out.x      = x_q;
    assign pix_out.y      = y_q;
    assign pix_out.colour = colour_q;

endmodule

`default_nettype wire

//--- draw_sprite/scene_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module scene_sequencer import sprite_pkg::*; (
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire logic       frame_start,
    input  wire coord_t     car_pos,
    input  wire coord_t     tower_pos,
    input  wire logic       car_done,
    input  wire logic       tower_done,
    input  wire pix_write_t car_pix,
    input  wire pix_write_t tower_pix,
    output logic            car_start,
    output logic            tower_start,
    output coord_t          car_origin,
    output coord_t          tower_origin,
    output pix_write_t      pix,
    output logic            frame_done,
    output logic            busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_car,
        st_tower
    } state_t;

    state_t state;
    logic   accept;

    // New frames only when fully idle, including the frame_done cycle
    assign accept = frame_start && !busy;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= st_idle;
            car_start   <= 1'b0;
            tower_start <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            car_start   <= 1'b0;
            tower_start <= 1'b0;
            frame_done  <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state     <= st_car;
                        car_start <= 1'b1;
                    end
                end
                st_car: begin
                    if (car_done) begin
                        state       <= st_tower;
                        tower_start <= 1'b1; // Tower follows the car
                    end
                end
                st_tower: begin
                    if (tower_done) begin
                        state      <= st_idle;
                        frame_done <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Positions held for the whole frame
    always_ff @(posedge clk) begin
        if (accept) begin
            car_origin   <= car_pos;
            tower_origin <= tower_pos;
        end
    end

    assign busy = (state != st_idle) || frame_done;

    // Idle drawer masked to zero, so OR is a clean merge of the active stream
    assign pix = (car_pix & {$bits(pix_write_t){car_pix.valid}})
               | (tower_pix & {$bits(pix_write_t){tower_pix.valid}});

endmodule

`default_nettype wire

//--- draw_sprite/draw_sprite.sv
`timescale 1ns/1ps
`default_nettype none

module draw_sprite import sprite_pkg::*; #(
    parameter int sprite_size = 20
) (
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire logic       start,
    input  wire coord_t     origin,
    input  wire logic       load_we,
    input  wire logic [8:0] load_addr,
    input  wire colour_t    load_colour,
    output pix_write_t      pix,
    output logic            done
);

    localparam int cnt_w = $clog2(sprite_size);
    localparam logic [cnt_w-1:0] last = cnt_w'(sprite_size - 1);

    logic             active;
    logic [cnt_w-1:0] col;
    logic [cnt_w-1:0] row;
    coord_t           origin_q;
    logic             valid_d;
    logic             last_d;
    logic [cnt_w-1:0] col_d;
    logic [cnt_w-1:0] row_d;
    logic [8:0]       scan_addr;
    logic [8:0]       mem_addr;
    colour_t          mem_colour;
    logic [8:0]       x_wide;
    logic [7:0]       y_wide;

    // Row-major address into the square image
    assign scan_addr = 9'(row) * 9'(sprite_size) + 9'(col);
    assign mem_addr  = load_we ? load_addr : scan_addr; // Loads take the port

    sprite_rom #(
        .sprite_size(sprite_size)
    ) rom_i (
        .clk  (clk),
        .we   (load_we),
        .addr (mem_addr),
        .wdata(load_colour),
        .rdata(mem_colour)
    );

    // Scan counters, one pixel per cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            active  <= 1'b0;
            col     <= '0;
            row     <= '0;
            valid_d <= 1'b0;
        end else begin
            valid_d <= active;
            if (start) begin
                active <= 1'b1;
                col    <= '0;
                row    <= '0;
            end else if (active) begin
                if (col == last) begin
                    col <= '0;
                    if (row == last) begin
                        active <= 1'b0; // Last address issued
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // Origin and offset staged to meet the memory read data
    always_ff @(posedge clk) begin
        if (start) begin
            origin_q <= origin;
        end
        col_d  <= col;
        row_d  <= row;
        last_d <= (col == last) && (row == last);
    end

    // One extra bit catches sums past the field range
    assign x_wide = {1'b0, origin_q.x} + 9'(col_d);
    assign y_wide = {1'b0, origin_q.y} + 8'(row_d);

    // Overflow saturates to all ones, which is off screen for the filter
    assign pix.valid  = valid_d;
    assign pix.x      = x_wide[8] ? 8'hFF : x_wide[7:0];
    assign pix.y      = y_wide[7] ? 7'h7F : y_wide[6:0];
    assign pix.colour = mem_colour;

    assign done = valid_d && last_d; // Together with the last pixel

endmodule

`default_nettype wire

//--- hw/sprite_rom.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_rom import sprite_pkg::*; #(
    parameter int sprite_size = 20
) (
    input  wire logic       clk,
    input  wire logic       we,
    input  wire logic [8:0] addr,
    input  wire colour_t    wdata,
    output colour_t         rdata
);

    localparam int depth = sprite_size * sprite_size;

    colour_t mem [depth];

    // Image is written by the caller before a frame, read during drawing
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // One cycle read latency
    end

endmodule

`default_nettype wire

//--- common/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

    // Visible screen size in pixels
    parameter int screen_w = 160;
    parameter int screen_h = 120;

    // 3 bits each of red, green and blue
    typedef logic [8:0] colour_t;

    // Transparent colour, never written to the framebuffer
    parameter colour_t colour_key = 9'h1FF;

    // Screen position or sprite origin
    typedef struct packed {
        logic [7:0] x;
        logic [6:0] y;
    } coord_t;

    // One framebuffer write
    typedef struct packed {
        logic       valid;
        logic [7:0] x;
        logic [6:0] y;
        colour_t    colour;
    } pix_write_t;

    typedef enum logic {
        sel_car   = 1'b0,
        sel_tower = 1'b1
    } sprite_sel_t;

    // One word loaded into a sprite image memory
    typedef struct packed {
        logic        valid;
        sprite_sel_t sel;
        logic [8:0]  addr;
        colour_t     colour;
    } sprite_load_t;

endpackage

`default_nettype wire
